// ==== additive_synth.f ====
source/additive_synth_pkg.sv
source/coeff_bank.sv
source/harmonic_phasor.sv
source/harmonic_mixer.sv
source/audio_bus_master.sv
source/additive_synth_top.sv
verification/audio_fifo_model.sv
verification/additive_synth_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the additive synth testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module additive_synth_tb \
	-f additive_synth.f \
	-o additive_synth_sim

./obj_dir/additive_synth_sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== source/additive_synth_pkg.sv ====
package additive_synth_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// 27-bit signed, coefficients and channel sums
	typedef logic signed [26:0] sample_t;
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	// 32 steps per period
	typedef logic [4:0] phase_t;
	typedef logic [4:0] harm_idx_t;
	typedef logic [3:0] shift_t;
	// free words reported by the audio FIFO
	typedef logic [7:0] fifo_space_t;

	localparam int num_harmonics = 21;

	////////////////////////////////////////////////////////////
	// audio FIFO slave map
	////////////////////////////////////////////////////////////

	localparam bus_addr_t fifo_addr = 32'h0000_3044;
	localparam bus_addr_t left_addr = 32'h0000_3048;
	localparam bus_addr_t right_addr = 32'h0000_304c;

	// write a pair only above this many free words
	localparam fifo_space_t min_space = 8'd2;
	// sum to codec word scaling
	localparam int sample_shift = 5;

	////////////////////////////////////////////////////////////
	// sine table
	////////////////////////////////////////////////////////////

	// round(32767 * sin(2*pi*p/32)), cosine is entry p+8
	localparam logic signed [15:0] sin_lut [32] = '{
		16'sd0, 16'sd6393, 16'sd12539, 16'sd18204,
		16'sd23170, 16'sd27245, 16'sd30273, 16'sd32137,
		16'sd32767, 16'sd32137, 16'sd30273, 16'sd27245,
		16'sd23170, 16'sd18204, 16'sd12539, 16'sd6393,
		16'sd0, -16'sd6393, -16'sd12539, -16'sd18204,
		-16'sd23170, -16'sd27245, -16'sd30273, -16'sd32137,
		-16'sd32767, -16'sd32137, -16'sd30273, -16'sd27245,
		-16'sd23170, -16'sd18204, -16'sd12539, -16'sd6393
	};

	// bus master states, one stereo pair per pass
	typedef enum logic [2:0] {
		poll_space,
		wait_space,
		decide,
		write_right,
		next_left,
		write_left
	} bus_state_t;

endpackage

// ==== source/additive_synth_top.sv ====
module additive_synth_top (
	input logic CLOCK_50,
	input logic reset,
	// host coefficient port
	input logic coeff_we,
	input additive_synth_pkg::harm_idx_t coeff_addr,
	input additive_synth_pkg::sample_t coeff_a,
	input additive_synth_pkg::sample_t coeff_b,
	input additive_synth_pkg::sample_t coeff_c,
	input additive_synth_pkg::sample_t coeff_d,
	input logic coeff_clear,
	input additive_synth_pkg::shift_t amp_shift,
	// audio FIFO bus
	output additive_synth_pkg::bus_addr_t bus_addr,
	output logic bus_read,
	output logic bus_write,
	output additive_synth_pkg::bus_data_t bus_write_data,
	input logic bus_ack,
	input additive_synth_pkg::bus_data_t bus_read_data
);

	additive_synth_pkg::sample_t coeff_a_q [additive_synth_pkg::num_harmonics];
	additive_synth_pkg::sample_t coeff_b_q [additive_synth_pkg::num_harmonics];
	additive_synth_pkg::sample_t coeff_c_q [additive_synth_pkg::num_harmonics];
	additive_synth_pkg::sample_t coeff_d_q [additive_synth_pkg::num_harmonics];
	// x is right, y is left
	additive_synth_pkg::sample_t sum_x;
	additive_synth_pkg::sample_t sum_y;
	// one pulse per finished stereo pair
	logic sample_advance;

	coeff_bank coeff_bank_i (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.coeff_we(coeff_we),
		.coeff_clear(coeff_clear),
		.coeff_addr(coeff_addr),
		.coeff_a(coeff_a),
		.coeff_b(coeff_b),
		.coeff_c(coeff_c),
		.coeff_d(coeff_d),
		.amp_shift(amp_shift),
		.coeff_a_q(coeff_a_q),
		.coeff_b_q(coeff_b_q),
		.coeff_c_q(coeff_c_q),
		.coeff_d_q(coeff_d_q)
	);

	harmonic_mixer harmonic_mixer_i (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.sample_advance(sample_advance),
		.coeff_a_q(coeff_a_q),
		.coeff_b_q(coeff_b_q),
		.coeff_c_q(coeff_c_q),
		.coeff_d_q(coeff_d_q),
		.sum_x(sum_x),
		.sum_y(sum_y)
	);

	audio_bus_master audio_bus_master_i (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.sum_x(sum_x),
		.sum_y(sum_y),
		.bus_ack(bus_ack),
		.bus_read_data(bus_read_data),
		.bus_addr(bus_addr),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_write_data(bus_write_data),
		.sample_advance(sample_advance)
	);

endmodule

// ==== source/audio_bus_master.sv ====
module audio_bus_master (
	input logic CLOCK_50,
	input logic reset,
	input additive_synth_pkg::sample_t sum_x,
	input additive_synth_pkg::sample_t sum_y,
	input logic bus_ack,
	input additive_synth_pkg::bus_data_t bus_read_data,
	output additive_synth_pkg::bus_addr_t bus_addr,
	output logic bus_read,
	output logic bus_write,
	output additive_synth_pkg::bus_data_t bus_write_data,
	output logic sample_advance
);

	additive_synth_pkg::bus_state_t state;
	// free words from the last poll
	additive_synth_pkg::fifo_space_t fifo_space;
	additive_synth_pkg::bus_data_t right_word;
	additive_synth_pkg::bus_data_t left_word;

	// sign extend to a bus word, then scale up
	function automatic additive_synth_pkg::bus_data_t to_word(
		input additive_synth_pkg::sample_t s
	);
		logic [31:0] ext;
		ext = {{5{s[26]}}, s};
		return ext << additive_synth_pkg::sample_shift;
	endfunction

	assign right_word = to_word(sum_x);
	assign left_word = to_word(sum_y);

	////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state <= additive_synth_pkg::poll_space;
			bus_read <= 1'b0;
			bus_write <= 1'b0;
			sample_advance <= 1'b0;
		end else begin
			// strobe lasts one cycle
			sample_advance <= 1'b0;
			case (state)
				additive_synth_pkg::poll_space: begin
					// ask the FIFO for its free space
					bus_addr <= additive_synth_pkg::fifo_addr;
					bus_read <= 1'b1;
					state <= additive_synth_pkg::wait_space;
				end
				additive_synth_pkg::wait_space: begin
					if (bus_ack) begin
						// write space is the top byte
						fifo_space <= bus_read_data[31:24];
						bus_read <= 1'b0;
						state <= additive_synth_pkg::decide;
					end
				end
				additive_synth_pkg::decide: begin
					if (fifo_space > additive_synth_pkg::min_space) begin
						// right channel first
						bus_addr <= additive_synth_pkg::right_addr;
						bus_write_data <= right_word;
						bus_write <= 1'b1;
						state <= additive_synth_pkg::write_right;
					end else begin
						// too full, poll again
						state <= additive_synth_pkg::poll_space;
					end
				end
				additive_synth_pkg::write_right: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state <= additive_synth_pkg::next_left;
					end
				end
				additive_synth_pkg::next_left: begin
					bus_addr <= additive_synth_pkg::left_addr;
					bus_write_data <= left_word;
					bus_write <= 1'b1;
					state <= additive_synth_pkg::write_left;
				end
				additive_synth_pkg::write_left: begin
					if (bus_ack) begin
						// pair done, step the phasors
						bus_write <= 1'b0;
						sample_advance <= 1'b1;
						state <= additive_synth_pkg::poll_space;
					end
				end
				default: begin
					bus_read <= 1'b0;
					bus_write <= 1'b0;
					state <= additive_synth_pkg::poll_space;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// bus protocol checks
	////////////////////////////////////////////////////////////

	assert property (@(posedge CLOCK_50) disable iff (reset) !(bus_read && bus_write))
		else $error("read and write requested together");

	// a pending request keeps its address, data and strobe
	assert property (@(posedge CLOCK_50) disable iff (reset)
		(bus_read || bus_write) && !bus_ack
		|=> $stable(bus_addr) && $stable(bus_read) && $stable(bus_write)
			&& (!bus_write || $stable(bus_write_data)))
		else $error("bus request changed before acknowledge");

endmodule

// ==== source/coeff_bank.sv ====
module coeff_bank (
	input logic CLOCK_50,
	input logic reset,
	input logic coeff_we,
	input logic coeff_clear,
	input additive_synth_pkg::harm_idx_t coeff_addr,
	input additive_synth_pkg::sample_t coeff_a,
	input additive_synth_pkg::sample_t coeff_b,
	input additive_synth_pkg::sample_t coeff_c,
	input additive_synth_pkg::sample_t coeff_d,
	input additive_synth_pkg::shift_t amp_shift,
	output additive_synth_pkg::sample_t coeff_a_q [additive_synth_pkg::num_harmonics],
	output additive_synth_pkg::sample_t coeff_b_q [additive_synth_pkg::num_harmonics],
	output additive_synth_pkg::sample_t coeff_c_q [additive_synth_pkg::num_harmonics],
	output additive_synth_pkg::sample_t coeff_d_q [additive_synth_pkg::num_harmonics]
);

	// address decode, anything past the last harmonic is dropped
	logic addr_ok;
	logic wr_hit;

	assign addr_ok = coeff_addr < additive_synth_pkg::harm_idx_t'(
		additive_synth_pkg::num_harmonics);
	assign wr_hit = coeff_we && addr_ok;

	////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		// clear has priority over a write
		if (reset || coeff_clear) begin
			for (int i = 0; i < additive_synth_pkg::num_harmonics; i++) begin
				coeff_a_q[i] <= '0;
				coeff_b_q[i] <= '0;
				coeff_c_q[i] <= '0;
				coeff_d_q[i] <= '0;
			end
		end else if (wr_hit) begin
			// amplitude scaled on the way in
			coeff_a_q[coeff_addr] <= coeff_a << amp_shift;
			coeff_b_q[coeff_addr] <= coeff_b << amp_shift;
			coeff_c_q[coeff_addr] <= coeff_c << amp_shift;
			coeff_d_q[coeff_addr] <= coeff_d << amp_shift;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// an entry only moves when its own address is written,
	// so a write past the bank touches nothing
	for (genvar g = 0; g < additive_synth_pkg::num_harmonics; g++) begin : g_hold
		assert property (@(posedge CLOCK_50) disable iff (reset)
			!coeff_clear && !(coeff_we && coeff_addr == g)
			|=> coeff_a_q[g] == $past(coeff_a_q[g]) && coeff_b_q[g] == $past(coeff_b_q[g])
				&& coeff_c_q[g] == $past(coeff_c_q[g])
				&& coeff_d_q[g] == $past(coeff_d_q[g]))
			else $error("coeff entry %0d changed without a write", g);
	end

endmodule

// ==== source/harmonic_mixer.sv ====
module harmonic_mixer (
	input logic CLOCK_50,
	input logic reset,
	input logic sample_advance,
	input additive_synth_pkg::sample_t coeff_a_q [additive_synth_pkg::num_harmonics],
	input additive_synth_pkg::sample_t coeff_b_q [additive_synth_pkg::num_harmonics],
	input additive_synth_pkg::sample_t coeff_c_q [additive_synth_pkg::num_harmonics],
	input additive_synth_pkg::sample_t coeff_d_q [additive_synth_pkg::num_harmonics],
	output additive_synth_pkg::sample_t sum_x,
	output additive_synth_pkg::sample_t sum_y
);

	// one output per harmonic and bank
	additive_synth_pkg::sample_t phasor_x [additive_synth_pkg::num_harmonics];
	additive_synth_pkg::sample_t phasor_y [additive_synth_pkg::num_harmonics];

	////////////////////////////////////////////////////////////
	// phasor banks
	////////////////////////////////////////////////////////////

	// harmonic k sits at index k-1
	for (genvar k = 1; k <= additive_synth_pkg::num_harmonics; k++) begin : g_harm
		// x bank, right channel
		harmonic_phasor #(
			.harmonic(k)
		) x_phasor (
			.CLOCK_50(CLOCK_50),
			.reset(reset),
			.sample_advance(sample_advance),
			.sine_mag(coeff_a_q[k-1]),
			.cosine_mag(coeff_b_q[k-1]),
			.phasor_out(phasor_x[k-1])
		);
		// y bank, left channel
		harmonic_phasor #(
			.harmonic(k)
		) y_phasor (
			.CLOCK_50(CLOCK_50),
			.reset(reset),
			.sample_advance(sample_advance),
			.sine_mag(coeff_c_q[k-1]),
			.cosine_mag(coeff_d_q[k-1]),
			.phasor_out(phasor_y[k-1])
		);
	end

	////////////////////////////////////////////////////////////
	// channel sums
	////////////////////////////////////////////////////////////

	// plain 27-bit adds, overflow wraps
	always_comb begin
		sum_x = '0;
		sum_y = '0;
		for (int j = 0; j < additive_synth_pkg::num_harmonics; j++) begin
			sum_x = sum_x + phasor_x[j];
			sum_y = sum_y + phasor_y[j];
		end
	end

endmodule

// ==== source/harmonic_phasor.sv ====
module harmonic_phasor #(
	// harmonic number, 1 to num_harmonics
	parameter int harmonic = 1
) (
	input logic CLOCK_50,
	input logic reset,
	input logic sample_advance,
	input additive_synth_pkg::sample_t sine_mag,
	input additive_synth_pkg::sample_t cosine_mag,
	output additive_synth_pkg::sample_t phasor_out
);

	// per-sample phase step
	localparam additive_synth_pkg::phase_t phase_step =
		additive_synth_pkg::phase_t'(harmonic);

	additive_synth_pkg::phase_t phase;
	// quarter period ahead gives cosine
	additive_synth_pkg::phase_t cos_phase;
	logic signed [15:0] sin_val;
	logic signed [15:0] cos_val;
	// 27 x 16 products, one guard bit for the sum
	logic signed [42:0] sin_term;
	logic signed [42:0] cos_term;
	logic signed [43:0] weighted;

	////////////////////////////////////////////////////////////
	// phase accumulator
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			phase <= '0;
		end else if (sample_advance) begin
			// wraps mod 32
			phase <= phase + phase_step;
		end
	end

	////////////////////////////////////////////////////////////
	// lookup and weighting
	////////////////////////////////////////////////////////////

	assign cos_phase = phase + additive_synth_pkg::phase_t'(8);
	assign sin_val = additive_synth_pkg::sin_lut[phase];
	assign cos_val = additive_synth_pkg::sin_lut[cos_phase];

	assign sin_term = sine_mag * sin_val;
	assign cos_term = cosine_mag * cos_val;

	// table is Q15, drop the fraction
	assign weighted = (sin_term + cos_term) >>> 15;

	// output lags the phase by a cycle
	always_ff @(posedge CLOCK_50) begin
		phasor_out <= weighted[26:0];
	end

endmodule

// ==== verification/additive_synth_tb.sv ====
module additive_synth_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// command codes in the tests file
	localparam logic [7:0] op_end = 8'h00;
	localparam logic [7:0] op_coeff = 8'h01;
	localparam logic [7:0] op_clear = 8'h02;
	localparam logic [7:0] op_shift = 8'h03;
	localparam logic [7:0] op_space = 8'h04;
	localparam logic [7:0] op_expect = 8'h05;
	localparam logic [7:0] op_watch = 8'h06;
	localparam int max_cmds = 64;
	// op, arg, then four data words
	localparam int words_per_cmd = 6;

	logic CLOCK_50;
	logic reset;
	logic coeff_we;
	logic coeff_clear;
	additive_synth_pkg::harm_idx_t coeff_addr;
	additive_synth_pkg::sample_t coeff_a;
	additive_synth_pkg::sample_t coeff_b;
	additive_synth_pkg::sample_t coeff_c;
	additive_synth_pkg::sample_t coeff_d;
	additive_synth_pkg::shift_t amp_shift;
	additive_synth_pkg::bus_addr_t bus_addr;
	logic bus_read;
	logic bus_write;
	additive_synth_pkg::bus_data_t bus_write_data;
	logic bus_ack;
	additive_synth_pkg::bus_data_t bus_read_data;
	logic space_load;
	additive_synth_pkg::fifo_space_t space_value;
	int write_count;
	int read_count;

	logic [31:0] tests [words_per_cmd * max_cmds];
	int n_cmds;
	int n_expect;
	int cycle_count = 0;
	int cycle_limit = 1000;
	// stereo pairs compared so far
	int pairs_checked;
	int value_errors;
	int other_errors;

	additive_synth_top dut_i (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.coeff_we(coeff_we),
		.coeff_addr(coeff_addr),
		.coeff_a(coeff_a),
		.coeff_b(coeff_b),
		.coeff_c(coeff_c),
		.coeff_d(coeff_d),
		.coeff_clear(coeff_clear),
		.amp_shift(amp_shift),
		.bus_addr(bus_addr),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_write_data(bus_write_data),
		.bus_ack(bus_ack),
		.bus_read_data(bus_read_data)
	);

	audio_fifo_model fifo_i (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.bus_addr(bus_addr),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_write_data(bus_write_data),
		.bus_ack(bus_ack),
		.bus_read_data(bus_read_data),
		.space_load(space_load),
		.space_value(space_value),
		.write_count(write_count),
		.read_count(read_count)
	);

	// 100 ns period
	always #50 CLOCK_50 = ~CLOCK_50;

	always @(posedge CLOCK_50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, samples stopped arriving", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// space polls go to the FIFO status word only
	always @(posedge CLOCK_50) begin
		if (!reset && bus_read && bus_ack
			&& bus_addr != additive_synth_pkg::fifo_addr) begin
			$display("CHECK FAILED at %0t: space read from %h, expected %h",
				$time, bus_addr, additive_synth_pkg::fifo_addr);
			value_errors++;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// inputs change 1 ns after the edge
	task automatic step();
		@(posedge CLOCK_50);
		#1;
	endtask

	// next logged pair against the expected words
	task automatic check_pair(input logic [31:0] exp_right, input logic [31:0] exp_left);
		int base;
		base = 2 * pairs_checked;
		while (write_count < base + 2) begin
			step();
		end
		if (fifo_i.log_addr[base] != additive_synth_pkg::right_addr) begin
			$display("CHECK FAILED at %0t: sample %0d first write to %h, expected %h",
				$time, pairs_checked, fifo_i.log_addr[base], additive_synth_pkg::right_addr);
			value_errors++;
		end
		if (fifo_i.log_data[base] != exp_right) begin
			$display("CHECK FAILED at %0t: sample %0d right word %h, expected %h",
				$time, pairs_checked, fifo_i.log_data[base], exp_right);
			value_errors++;
		end
		if (fifo_i.log_addr[base + 1] != additive_synth_pkg::left_addr) begin
			$display("CHECK FAILED at %0t: sample %0d second write to %h, expected %h",
				$time, pairs_checked, fifo_i.log_addr[base + 1], additive_synth_pkg::left_addr);
			value_errors++;
		end
		if (fifo_i.log_data[base + 1] != exp_left) begin
			$display("CHECK FAILED at %0t: sample %0d left word %h, expected %h",
				$time, pairs_checked, fifo_i.log_data[base + 1], exp_left);
			value_errors++;
		end
		pairs_checked++;
	endtask

	// FIFO full, only space polls allowed
	task automatic watch_idle(input int cycles);
		int writes_before;
		int reads_before;
		writes_before = write_count;
		reads_before = read_count;
		repeat (cycles) step();
		if (write_count != writes_before) begin
			$display("sample writes appeared while the FIFO had no room");
			other_errors++;
		end
		if (read_count < reads_before + 2) begin
			$display("the master stopped polling the FIFO space");
			other_errors++;
		end
	endtask

	task automatic run_command(input int idx);
		logic [7:0] op;
		logic [7:0] arg;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		op = tests[words_per_cmd * idx][7:0];
		arg = tests[words_per_cmd * idx + 1][7:0];
		f0 = tests[words_per_cmd * idx + 2];
		f1 = tests[words_per_cmd * idx + 3];
		f2 = tests[words_per_cmd * idx + 4];
		f3 = tests[words_per_cmd * idx + 5];
		case (op)
			op_coeff: begin
				coeff_addr = arg[4:0];
				coeff_a = f0[26:0];
				coeff_b = f1[26:0];
				coeff_c = f2[26:0];
				coeff_d = f3[26:0];
				coeff_we = 1'b1;
				step();
				coeff_we = 1'b0;
			end
			op_clear: begin
				coeff_clear = 1'b1;
				step();
				coeff_clear = 1'b0;
			end
			op_shift: begin
				// level, held until the next shift command
				amp_shift = arg[3:0];
				step();
			end
			op_space: begin
				space_value = arg;
				space_load = 1'b1;
				step();
				space_load = 1'b0;
			end
			op_expect: check_pair(f0, f1);
			op_watch: watch_idle(int'(arg));
			default: begin
				$display("unknown command %h in the tests file", op);
				other_errors++;
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		CLOCK_50 = 1'b0;
		reset = 1'b1;
		coeff_we = 1'b0;
		coeff_clear = 1'b0;
		coeff_addr = '0;
		coeff_a = '0;
		coeff_b = '0;
		coeff_c = '0;
		coeff_d = '0;
		amp_shift = '0;
		space_load = 1'b0;
		space_value = '0;
		pairs_checked = 0;
		value_errors = 0;
		other_errors = 0;
		for (int i = 0; i < words_per_cmd * max_cmds; i++) begin
			tests[i] = '0;
		end
		$readmemh("verification/additive_synth_tests.txt", tests);
		// count commands up to the end marker
		n_cmds = 0;
		n_expect = 0;
		while (n_cmds < max_cmds && tests[words_per_cmd * n_cmds][7:0] != op_end) begin
			if (tests[words_per_cmd * n_cmds][7:0] == op_expect) begin
				n_expect++;
			end
			n_cmds++;
		end
		cycle_limit = 200 * n_expect + 50 * n_cmds;
		repeat (8) @(posedge CLOCK_50);
		#1;
		reset = 1'b0;
		for (int i = 0; i < n_cmds; i++) begin
			run_command(i);
		end
		// FIFO drained to 2, nothing more may arrive
		repeat (20) step();
		if (write_count != 2 * pairs_checked) begin
			$display("%0d writes logged but %0d expected", write_count, 2 * pairs_checked);
			other_errors++;
		end
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/additive_synth_tests.txt ====
// columns: op arg f0 f1 f2 f3 (hex, one command per line)
// 01 coeff write arg=addr f0..f3=a b c d, 02 clear, 03 shift arg, 04 space arg
// 05 expect pair f0=right word f1=left word, 06 watch idle arg=cycles, 00 end
04 08 00000000 00000000 00000000 00000000
05 00 00000000 00000000 00000000 00000000
05 00 00000000 00000000 00000000 00000000
05 00 00000000 00000000 00000000 00000000
04 02 00000000 00000000 00000000 00000000
06 1e 00000000 00000000 00000000 00000000
// harmonic 1 cosine, n = 3 to 6
01 00 00000000 00008000 00000000 00000000
04 0a 00000000 00000000 00000000 00000000
05 00 000d4da0 00000000 00000000 00000000
05 00 000b5040 00000000 00000000 00000000
05 00 0008e380 00000000 00000000 00000000
05 00 00061f60 00000000 00000000 00000000
// harmonics 3 and 5 with shift 2, n = 7 to 9
02 00 00000000 00000000 00000000 00000000
03 02 00000000 00000000 00000000 00000000
01 02 00000000 00000000 00002000 00002000
01 04 00000000 00000000 00001000 00000000
04 08 00000000 00000000 00000000 00000000
05 00 00000000 ffee40a0 00000000 00000000
05 00 00000000 fff80000 00000000 00000000
05 00 00000000 000007a0 00000000 00000000
// clear, then a write past the bank
02 00 00000000 00000000 00000000 00000000
01 19 00000100 00000100 00000100 00000100
04 06 00000000 00000000 00000000 00000000
05 00 00000000 00000000 00000000 00000000
05 00 00000000 00000000 00000000 00000000
// harmonic 2 sine, n = 12 to 16
03 00 00000000 00000000 00000000 00000000
01 01 00008000 00000000 00000000 00000000
04 0c 00000000 00000000 00000000 00000000
05 00 fff00020 00000000 00000000 00000000
05 00 fff137e0 00000000 00000000 00000000
05 00 fff4afc0 00000000 00000000 00000000
05 00 fff9e0a0 00000000 00000000 00000000
05 00 00000000 00000000 00000000 00000000
00 00 00000000 00000000 00000000 00000000

// ==== verification/audio_fifo_model.sv ====
module audio_fifo_model (
	input logic CLOCK_50,
	input logic reset,
	input additive_synth_pkg::bus_addr_t bus_addr,
	input logic bus_read,
	input logic bus_write,
	input additive_synth_pkg::bus_data_t bus_write_data,
	output logic bus_ack,
	output additive_synth_pkg::bus_data_t bus_read_data,
	// free space loaded by the testbench
	input logic space_load,
	input additive_synth_pkg::fifo_space_t space_value,
	output int write_count,
	output int read_count
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int log_depth = 256;

	// one entry per acknowledged write
	additive_synth_pkg::bus_addr_t log_addr [log_depth];
	additive_synth_pkg::bus_data_t log_data [log_depth];
	// free words, each accepted write takes one
	additive_synth_pkg::fifo_space_t space;
	logic [31:0] lcg_state;
	logic [31:0] lcg_peek;
	logic busy;
	// extra cycles before the ack, 0 to 3
	logic [1:0] wait_left;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	assign lcg_peek = lcg_next(lcg_state);

	initial begin
		bus_ack = 1'b0;
		bus_read_data = '0;
	end

	////////////////////////////////////////////////////////////
	// slave handshake
	////////////////////////////////////////////////////////////

	always @(posedge CLOCK_50) begin
		if (reset) begin
			bus_ack <= 1'b0;
			bus_read_data <= '0;
			busy <= 1'b0;
			wait_left <= 2'd0;
			space <= '0;
			lcg_state <= 32'd51;
			write_count <= 0;
			read_count <= 0;
		end else begin
			bus_ack <= 1'b0;
			if ((bus_read || bus_write) && !bus_ack && !busy) begin
				// new request, draw its delay
				lcg_state <= lcg_peek;
				wait_left <= lcg_peek[17:16];
				busy <= 1'b1;
			end else if (busy && wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else if (busy) begin
				bus_ack <= 1'b1;
				busy <= 1'b0;
				if (bus_write) begin
					if (write_count < log_depth) begin
						log_addr[write_count] <= bus_addr;
						log_data[write_count] <= bus_write_data;
					end
					write_count <= write_count + 1;
					if (space != '0) begin
						space <= space - 8'd1;
					end
				end else begin
					// space goes out in the top byte
					bus_read_data <= {space, 24'h000000};
					read_count <= read_count + 1;
				end
			end
			// a load from the testbench wins
			if (space_load) begin
				space <= space_value;
			end
		end
	end

endmodule
